/* filelist.f */
hw/bus_pkg.sv
hw/soc_map_pkg.sv
hw/reset_seq.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/dev_table.sv
hw/int_ctrl.sv
hw/scratch_ram.sv
hw/soc_top.sv
test/soc_properties.sv
test/tb_soc.sv

/* Makefile */
TOP := tb_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_soc.sv */
// Directed testbench for the SoC interconnect with bus tasks, checks, monitors and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_soc;

	// Tests take roughly 600 cycles so the limit leaves a wide margin
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int RST_HOLD       = 8;
	localparam int RST_CYCLES     = 16;

	// Word addresses of the map windows
	localparam bus_pkg::addr_t DEVTBL_W = 30'h000;
	localparam bus_pkg::addr_t INTC_W   = 30'h400;
	localparam bus_pkg::addr_t RAM_W    = 30'h800;
	localparam bus_pkg::addr_t NOMAP_W  = 30'hC00;

	logic                                  clk24mhz;
	logic                                  rst_p;
	bus_pkg::op_e                          m_op    [bus_pkg::MASTER_COUNT];
	bus_pkg::addr_t                        m_addr  [bus_pkg::MASTER_COUNT];
	bus_pkg::data_t                        m_wdata [bus_pkg::MASTER_COUNT];
	bus_pkg::sel_t                         m_sel   [bus_pkg::MASTER_COUNT];
	logic [bus_pkg::MASTER_COUNT-1:0]      m_rdy;
	bus_pkg::data_t                        m_rdata;
	logic [soc_map_pkg::IRQ_SRC_COUNT-1:0] irq_src;
	logic [soc_map_pkg::IRQ_SRC_COUNT-1:0] src_ack;
	logic [bus_pkg::MASTER_COUNT-1:0]      irq_dst;
	logic                                  sys_rst;
	logic                                  power_off;

	logic [31:0] rng_state = 32'hbcd9_8a89;
	string       cur_test = "reset";
	int          cycle_cnt = 0;
	int          acc_cnt [bus_pkg::MASTER_COUNT];
	int          ack_cnt [soc_map_pkg::IRQ_SRC_COUNT];
	int          max_skew;
	logic        arb_active;

	soc_top #(.RAM_WORDS(1024), .RST_CYCLES(RST_CYCLES)) u_dut (
		.clk24mhz    (clk24mhz),
		.rst_p       (rst_p),
		.m_op_i      (m_op),
		.m_addr_i    (m_addr),
		.m_wdata_i   (m_wdata),
		.m_sel_i     (m_sel),
		.m_rdy_o     (m_rdy),
		.m_rdata_o   (m_rdata),
		.irq_src_i   (irq_src),
		.src_ack_o   (src_ack),
		.irq_dst_o   (irq_dst),
		.sys_rst_o   (sys_rst),
		.power_off_o (power_off)
	);

	initial clk24mhz = 1'b0;
	always #4 clk24mhz = ~clk24mhz;

	always @(posedge clk24mhz) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a transfer or reset never finished",
				TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	// Accepts and acks counted mid-cycle where the outputs are settled
	always @(negedge clk24mhz) begin
		int skew;
		for (int m = 0; m < bus_pkg::MASTER_COUNT; m++) begin
			if (m_rdy[m])
				acc_cnt[m]++;
		end
		for (int s = 0; s < soc_map_pkg::IRQ_SRC_COUNT; s++) begin
			if (src_ack[s])
				ack_cnt[s]++;
		end
		skew = acc_cnt[0] > acc_cnt[1] ? acc_cnt[0] - acc_cnt[1] : acc_cnt[1] - acc_cnt[0];
		if (arb_active && skew > max_skew)
			max_skew = skew;
	end

	function automatic bus_pkg::data_t next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Expected word after a byte-select write
	function automatic bus_pkg::data_t merge_bytes(bus_pkg::data_t old_w, bus_pkg::data_t new_w,
			bus_pkg::sel_t sel);
		bus_pkg::data_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error in %s, %s: expected %h, actual %h", cur_test, what, expected,
				actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Called right after a rising edge, returns on the accepting edge
	task automatic bus_write(input int m, input bus_pkg::addr_t addr, input bus_pkg::data_t data,
			input bus_pkg::sel_t sel);
		m_op[m]    <= bus_pkg::OP_WRITE;
		m_addr[m]  <= addr;
		m_wdata[m] <= data;
		m_sel[m]   <= sel;
		@(negedge clk24mhz);
		while (!m_rdy[m])
			@(negedge clk24mhz);
		@(posedge clk24mhz);
		m_op[m] <= bus_pkg::OP_IDLE;
	endtask

	// Data is taken in the cycle after acceptance
	task automatic bus_read(input int m, input bus_pkg::addr_t addr, output bus_pkg::data_t data);
		m_op[m]   <= bus_pkg::OP_READ;
		m_addr[m] <= addr;
		m_sel[m]  <= 4'hf;
		@(negedge clk24mhz);
		while (!m_rdy[m])
			@(negedge clk24mhz);
		@(posedge clk24mhz);
		m_op[m] <= bus_pkg::OP_IDLE;
		@(negedge clk24mhz);
		data = m_rdata;
		@(posedge clk24mhz);
	endtask

	task automatic apply_reset();
		rst_p <= 1'b1;
		repeat (RST_HOLD) @(posedge clk24mhz);
		rst_p <= 1'b0;
		@(negedge clk24mhz);
		while (sys_rst)
			@(negedge clk24mhz);
		@(posedge clk24mhz);
	endtask

	task automatic dev_table_reads();
		bus_pkg::data_t exp_tbl [11];
		bus_pkg::data_t rd;
		cur_test = "device table";
		exp_tbl = '{32'd6, 32'd4, 32'd7, 32'h1000, 32'd3, 32'h1000, 32'd1, 32'h1000, 32'd0,
			32'h1000, 32'd0};
		for (int m = 0; m < bus_pkg::MASTER_COUNT; m++) begin
			for (int w = 0; w < 11; w++) begin
				bus_read(m, bus_pkg::addr_t'(DEVTBL_W + w), rd);
				check_value($sformatf("word %0d via master %0d", w, m), exp_tbl[w], rd);
			end
		end
		bus_write(0, RAM_W + 30'd5, 32'h1234_5678, 4'hf);
		bus_write(0, NOMAP_W + 30'd5, 32'hdead_beef, 4'hf);
		bus_read(1, NOMAP_W + 30'd5, rd);
		check_value("unmapped read after write", 32'h0, rd);
		bus_read(0, 30'h3fff_ffff, rd);
		check_value("top of address space", 32'h0, rd);
		bus_read(1, RAM_W + 30'd5, rd);
		check_value("RAM beside dropped write", 32'h1234_5678, rd);
	endtask

	task automatic ram_readback();
		bus_pkg::data_t wr [16];
		bus_pkg::data_t rd;
		bus_pkg::data_t exp_w;
		bus_pkg::data_t new_w;
		bus_pkg::sel_t  sels [4];
		cur_test = "scratch RAM";
		for (int i = 0; i < 16; i++) begin
			wr[i] = next_rand();
			bus_write(i % 2, bus_pkg::addr_t'(RAM_W + 61 * i), wr[i], 4'hf);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read((i + 1) % 2, bus_pkg::addr_t'(RAM_W + 61 * i), rd);
			check_value($sformatf("word %0d", 61 * i), wr[i], rd);
		end
		sels = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
		exp_w = next_rand();
		bus_write(0, RAM_W + 30'd500, exp_w, 4'hf);
		for (int k = 0; k < 4; k++) begin
			new_w = next_rand();
			exp_w = merge_bytes(exp_w, new_w, sels[k]);
			bus_write(k % 2, RAM_W + 30'd500, new_w, sels[k]);
			bus_read(0, RAM_W + 30'd500, rd);
			check_value($sformatf("byte select %b", sels[k]), exp_w, rd);
		end
	endtask

	task automatic arbitration_fairness();
		bus_pkg::data_t wr [2][20];
		bus_pkg::data_t rd;
		cur_test = "arbitration";
		for (int m = 0; m < 2; m++) begin
			for (int i = 0; i < 20; i++)
				wr[m][i] = next_rand();
		end
		acc_cnt[0] = 0;
		acc_cnt[1] = 0;
		max_skew = 0;
		arb_active = 1'b1;
		// Both masters keep the bus busy at the same time
		fork
			for (int i = 0; i < 20; i++)
				bus_write(0, bus_pkg::addr_t'(RAM_W + 600 + i), wr[0][i], 4'hf);
			for (int i = 0; i < 20; i++)
				bus_write(1, bus_pkg::addr_t'(RAM_W + 700 + i), wr[1][i], 4'hf);
		join
		arb_active = 1'b0;
		check_value("master 0 accepts", 32'd20, acc_cnt[0]);
		check_value("master 1 accepts", 32'd20, acc_cnt[1]);
		check_value("accept counts within one", 32'd1, max_skew <= 1);
		for (int i = 0; i < 20; i++) begin
			bus_read(1, bus_pkg::addr_t'(RAM_W + 600 + i), rd);
			check_value($sformatf("master 0 word %0d", i), wr[0][i], rd);
			bus_read(0, bus_pkg::addr_t'(RAM_W + 700 + i), rd);
			check_value($sformatf("master 1 word %0d", i), wr[1][i], rd);
		end
	endtask

	task automatic interrupt_claim();
		bus_pkg::data_t rd;
		cur_test = "interrupts";
		bus_write(0, INTC_W + 30'd1, 32'h1, 4'hf);
		bus_read(1, INTC_W + 30'd1, rd);
		check_value("enable mask", 32'h1, rd);
		@(negedge clk24mhz);
		check_value("destinations before the edge", 32'h0, irq_dst);
		@(posedge clk24mhz);
		irq_src[1] <= 1'b1;
		// Pending follows on the next edge
		@(posedge clk24mhz);
		@(negedge clk24mhz);
		check_value("destinations after source 1 rises", 32'h1, irq_dst);
		ack_cnt[0] = 0;
		ack_cnt[1] = 0;
		@(posedge clk24mhz);
		bus_read(0, INTC_W, rd);
		check_value("claim", 32'd2, rd);
		bus_read(1, INTC_W + 30'd2, rd);
		check_value("pending after claim", 32'h0, rd);
		check_value("source 1 ack cycles", 32'd1, ack_cnt[1]);
		check_value("source 0 ack cycles", 32'd0, ack_cnt[0]);
		@(negedge clk24mhz);
		check_value("destinations after claim", 32'h0, irq_dst);
		@(posedge clk24mhz);
		irq_src[1] <= 1'b0;
	endtask

	task automatic reset_commands();
		bus_pkg::data_t keep;
		bus_pkg::data_t rd;
		int             rst_len;
		cur_test = "reset commands";
		keep = next_rand();
		bus_write(0, RAM_W + 30'd900, keep, 4'hf);
		// Warm restart through the command register
		bus_write(1, DEVTBL_W, 32'h2, 4'hf);
		rst_len = 0;
		@(posedge clk24mhz);
		// Master 0 requests as the restart begins and has to wait it out
		fork
			bus_read(0, RAM_W + 30'd900, rd);
			begin
				@(negedge clk24mhz);
				while (!sys_rst)
					@(negedge clk24mhz);
				while (sys_rst) begin
					check_value("ready during reset", 32'h0, m_rdy);
					rst_len++;
					@(negedge clk24mhz);
				end
			end
		join
		check_value("warm reset length", 32'd1, rst_len >= RST_CYCLES);
		check_value("RAM after warm reset", keep, rd);
		bus_read(1, INTC_W + 30'd1, rd);
		check_value("enable mask after warm reset", 32'h0, rd);
		bus_write(0, DEVTBL_W, 32'h1, 4'hf);
		@(negedge clk24mhz);
		while (!power_off)
			@(negedge clk24mhz);
		repeat (20) @(negedge clk24mhz);
		check_value("power-off held", 32'd1, power_off);
		check_value("no restart from power-off", 32'd0, sys_rst);
		@(posedge clk24mhz);
		apply_reset();
		@(negedge clk24mhz);
		check_value("power-off after external reset", 32'd0, power_off);
		@(posedge clk24mhz);
	endtask

	initial begin
		rst_p = 1'b1;
		irq_src = '0;
		arb_active = 1'b0;
		max_skew = 0;
		for (int m = 0; m < bus_pkg::MASTER_COUNT; m++) begin
			m_op[m]    = bus_pkg::OP_IDLE;
			m_addr[m]  = '0;
			m_wdata[m] = '0;
			m_sel[m]   = '0;
			acc_cnt[m] = 0;
		end
		for (int s = 0; s < soc_map_pkg::IRQ_SRC_COUNT; s++)
			ack_cnt[s] = 0;
		@(posedge clk24mhz);
		apply_reset();
		dev_table_reads();
		ram_readback();
		arbitration_fairness();
		interrupt_claim();
		reset_commands();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/soc_properties.sv */
// Arbiter assertions for a single ready, no ready to an idle master and a quiet bus in reset
`timescale 1ns/1ns
`default_nettype none

module soc_properties (
	input wire                              clk24mhz,
	input wire                              rst_p,
	input wire bus_pkg::op_e                op_i [bus_pkg::MASTER_COUNT],
	input wire [bus_pkg::MASTER_COUNT-1:0]  rdy_i
);

	// Only one transfer can be accepted per cycle
	single_ready: assert property (@(posedge clk24mhz) $onehot0(rdy_i))
		else $error("more than one master ready in the same cycle");

	for (genvar m = 0; m < bus_pkg::MASTER_COUNT; m++) begin : g_idle
		idle_not_ready: assert property (@(posedge clk24mhz)
				op_i[m] == bus_pkg::OP_IDLE |-> !rdy_i[m])
			else $error("ready given to idle master %0d", m);
	end

	quiet_in_reset: assert property (@(posedge clk24mhz) rst_p |-> rdy_i == '0)
		else $error("master ready while the system reset is active");

endmodule

bind bus_arbiter soc_properties u_arb_props (
	.clk24mhz (clk24mhz),
	.rst_p    (rst_p),
	.op_i     (m_op_i),
	.rdy_i    (m_rdy_o)
);

`default_nettype wire

/* hw/soc_top.sv */
// SoC interconnect top level with reset sequencer, arbiter, decoder and the three slaves
`timescale 1ns/1ns
`default_nettype none

module soc_top #(
	parameter int RAM_WORDS  = 1024,
	parameter int RST_CYCLES = 16
) (
	input  wire                                         clk24mhz,
	input  wire                                         rst_p,
	input  wire bus_pkg::op_e                           m_op_i    [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::addr_t                         m_addr_i  [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::data_t                         m_wdata_i [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::sel_t                          m_sel_i   [bus_pkg::MASTER_COUNT],
	output logic [bus_pkg::MASTER_COUNT-1:0]            m_rdy_o,
	output bus_pkg::data_t                              m_rdata_o,
	input  wire [soc_map_pkg::IRQ_SRC_COUNT-1:0]        irq_src_i,
	output logic [soc_map_pkg::IRQ_SRC_COUNT-1:0]       src_ack_o,
	output logic [bus_pkg::MASTER_COUNT-1:0]            irq_dst_o,
	output logic                                        sys_rst_o,
	output logic                                        power_off_o
);

	wire soc_map_pkg::rst_cmd_e rst_cmd;

	wire bus_pkg::op_e   bus_op;
	wire bus_pkg::addr_t bus_addr;
	wire bus_pkg::data_t bus_wdata;
	wire bus_pkg::sel_t  bus_sel;
	wire                 bus_rdy;

	wire [bus_pkg::SLAVE_COUNT-1:0] s_we;
	wire [bus_pkg::SLAVE_COUNT-1:0] s_re;
	wire bus_pkg::addr_t s_addr;
	wire bus_pkg::data_t s_wdata;
	wire bus_pkg::sel_t  s_sel;

	wire bus_pkg::data_t devtbl_rdata;
	wire bus_pkg::data_t intctrl_rdata;
	wire bus_pkg::data_t ram_rdata;

	reset_seq #(.RST_CYCLES(RST_CYCLES)) u_reset_seq (
		.clk24mhz    (clk24mhz),
		.rst_p       (rst_p),
		.rst_cmd_i   (rst_cmd),
		.sys_rst_o   (sys_rst_o),
		.power_off_o (power_off_o)
	);

	bus_arbiter u_arbiter (
		.clk24mhz    (clk24mhz),
		.rst_p       (sys_rst_o),
		.m_op_i      (m_op_i),
		.m_addr_i    (m_addr_i),
		.m_wdata_i   (m_wdata_i),
		.m_sel_i     (m_sel_i),
		.m_rdy_o     (m_rdy_o),
		.bus_op_o    (bus_op),
		.bus_addr_o  (bus_addr),
		.bus_wdata_o (bus_wdata),
		.bus_sel_o   (bus_sel),
		.bus_rdy_i   (bus_rdy)
	);

	// Read data returns to both masters on one shared port
	bus_decoder u_decoder (
		.clk24mhz        (clk24mhz),
		.rst_p           (sys_rst_o),
		.bus_op_i        (bus_op),
		.bus_addr_i      (bus_addr),
		.bus_wdata_i     (bus_wdata),
		.bus_sel_i       (bus_sel),
		.bus_rdy_o       (bus_rdy),
		.bus_rdata_o     (m_rdata_o),
		.s_we_o          (s_we),
		.s_re_o          (s_re),
		.s_addr_o        (s_addr),
		.s_wdata_o       (s_wdata),
		.s_sel_o         (s_sel),
		.devtbl_rdata_i  (devtbl_rdata),
		.intctrl_rdata_i (intctrl_rdata),
		.ram_rdata_i     (ram_rdata)
	);

	dev_table u_dev_table (
		.clk24mhz  (clk24mhz),
		.rst_p     (sys_rst_o),
		.we_i      (s_we[bus_pkg::SLV_DEVTBL]),
		.re_i      (s_re[bus_pkg::SLV_DEVTBL]),
		.addr_i    (s_addr),
		.wdata_i   (s_wdata),
		.rdata_o   (devtbl_rdata),
		.rst_cmd_o (rst_cmd)
	);

	int_ctrl u_int_ctrl (
		.clk24mhz  (clk24mhz),
		.rst_p     (sys_rst_o),
		.we_i      (s_we[bus_pkg::SLV_INTCTRL]),
		.re_i      (s_re[bus_pkg::SLV_INTCTRL]),
		.addr_i    (s_addr),
		.wdata_i   (s_wdata),
		.rdata_o   (intctrl_rdata),
		.irq_src_i (irq_src_i),
		.src_ack_o (src_ack_o),
		.irq_dst_o (irq_dst_o)
	);

	// Contents survive any reset
	scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_scratch_ram (
		.clk24mhz (clk24mhz),
		.we_i     (s_we[bus_pkg::SLV_RAM]),
		.re_i     (s_re[bus_pkg::SLV_RAM]),
		.addr_i   (s_addr),
		.wdata_i  (s_wdata),
		.sel_i    (s_sel),
		.rdata_o  (ram_rdata)
	);

endmodule

`default_nettype wire

/* hw/scratch_ram.sv */
// Scratch word RAM with byte-select writes and a registered read port
`timescale 1ns/1ns
`default_nettype none

module scratch_ram #(
	parameter int RAM_WORDS = 1024
) (
	input  wire                 clk24mhz,
	input  wire                 we_i,
	input  wire                 re_i,
	input  wire bus_pkg::addr_t addr_i,
	input  wire bus_pkg::data_t wdata_i,
	input  wire bus_pkg::sel_t  sel_i,
	output bus_pkg::data_t      rdata_o
);

	localparam int IDX_W = $clog2(RAM_WORDS);

	bus_pkg::data_t   mem [RAM_WORDS];
	logic [IDX_W-1:0] idx;

	// Addresses past the end wrap around
	assign idx = IDX_W'(addr_i % RAM_WORDS);

	always_ff @(posedge clk24mhz) begin
		if (we_i) begin
			for (int b = 0; b < 4; b++) begin
				if (sel_i[b])
					mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
		if (re_i)
			rdata_o <= mem[idx];
	end

endmodule

`default_nettype wire

/* hw/int_ctrl.sv */
// Interrupt controller with edge-set pending bits, destination enables and a claim register
`timescale 1ns/1ns
`default_nettype none

module int_ctrl (
	input  wire                                   clk24mhz,
	input  wire                                   rst_p,
	input  wire                                   we_i,
	input  wire                                   re_i,
	input  wire bus_pkg::addr_t                   addr_i,
	input  wire bus_pkg::data_t                   wdata_i,
	output bus_pkg::data_t                        rdata_o,
	input  wire [soc_map_pkg::IRQ_SRC_COUNT-1:0]  irq_src_i,
	output logic [soc_map_pkg::IRQ_SRC_COUNT-1:0] src_ack_o,
	output logic [bus_pkg::MASTER_COUNT-1:0]      irq_dst_o
);

	localparam int SRC_N = soc_map_pkg::IRQ_SRC_COUNT;
	localparam int DST_N = bus_pkg::MASTER_COUNT;

	logic [SRC_N-1:0] src_q;
	logic [SRC_N-1:0] pend_q;
	logic [SRC_N-1:0] claim_clr;
	logic [DST_N-1:0] en_q;
	bus_pkg::data_t   claim_word;
	bus_pkg::data_t   reg_word;
	logic             claim_rd;

	assign claim_rd = re_i && addr_i == bus_pkg::addr_t'(0);

	// Lowest pending source wins, reported as index plus one
	always_comb begin
		claim_word = '0;
		claim_clr  = '0;
		for (int s = SRC_N - 1; s >= 0; s--) begin
			if (pend_q[s]) begin
				claim_word = bus_pkg::data_t'(s + 1);
				claim_clr  = '0;
				claim_clr[s] = claim_rd;
			end
		end
	end

	always_comb begin
		case (addr_i)
			bus_pkg::addr_t'(0): reg_word = claim_word;
			bus_pkg::addr_t'(1): reg_word = bus_pkg::data_t'(en_q);
			bus_pkg::addr_t'(2): reg_word = bus_pkg::data_t'(pend_q);
			default:             reg_word = '0;
		endcase
	end

	always_ff @(posedge clk24mhz) begin
		if (re_i)
			rdata_o <= reg_word;
	end

	// A new edge in the claim cycle is kept pending
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			src_q     <= '0;
			pend_q    <= '0;
			en_q      <= '0;
			src_ack_o <= '0;
		end else begin
			src_q     <= irq_src_i;
			pend_q    <= (pend_q & ~claim_clr) | (irq_src_i & ~src_q);
			src_ack_o <= claim_clr;
			if (we_i && addr_i == bus_pkg::addr_t'(1))
				en_q <= wdata_i[DST_N-1:0];
		end
	end

	assign irq_dst_o = {DST_N{|pend_q}} & en_q;

endmodule

`default_nettype wire

/* hw/dev_table.sv */
// Device description table with the software reset command register
`timescale 1ns/1ns
`default_nettype none

module dev_table (
	input  wire                   clk24mhz,
	input  wire                   rst_p,
	input  wire                   we_i,
	input  wire                   re_i,
	input  wire bus_pkg::addr_t   addr_i,
	input  wire bus_pkg::data_t   wdata_i,
	output bus_pkg::data_t        rdata_o,
	output soc_map_pkg::rst_cmd_e rst_cmd_o
);

	// Identifiers in slave_e order, the default slave last
	localparam bus_pkg::data_t DEV_IDS [bus_pkg::SLAVE_COUNT] = '{
		soc_map_pkg::DEV_ID_DEVTBL,
		soc_map_pkg::DEV_ID_INTCTRL,
		soc_map_pkg::DEV_ID_RAM,
		soc_map_pkg::DEV_ID_INVALID
	};

	bus_pkg::data_t tbl_word;

	always_comb begin
		tbl_word = '0;
		if (addr_i == bus_pkg::addr_t'(0))
			tbl_word = soc_map_pkg::SOC_ID;
		else if (addr_i == bus_pkg::addr_t'(1))
			tbl_word = bus_pkg::data_t'(bus_pkg::SLAVE_COUNT);
		// Two words per slave, identifier then map size
		for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
			if (addr_i == bus_pkg::addr_t'(2 + 2 * i))
				tbl_word = DEV_IDS[i];
			if (addr_i == bus_pkg::addr_t'(3 + 2 * i))
				tbl_word = soc_map_pkg::MAP_SIZE;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (re_i)
			rdata_o <= tbl_word;
	end

	// Command stays until the reset it causes clears it
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			rst_cmd_o <= soc_map_pkg::RST_NONE;
		else if (we_i && addr_i == bus_pkg::addr_t'(0))
			rst_cmd_o <= soc_map_pkg::rst_cmd_e'(wdata_i[1:0]);
	end

endmodule

`default_nettype wire

/* hw/bus_decoder.sv */
// Address decoder with slave strobes, offset address, default slave and read-data return
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
	input  wire                             clk24mhz,
	input  wire                             rst_p,
	input  wire bus_pkg::op_e               bus_op_i,
	input  wire bus_pkg::addr_t             bus_addr_i,
	input  wire bus_pkg::data_t             bus_wdata_i,
	input  wire bus_pkg::sel_t              bus_sel_i,
	output logic                            bus_rdy_o,
	output bus_pkg::data_t                  bus_rdata_o,
	output logic [bus_pkg::SLAVE_COUNT-1:0] s_we_o,
	output logic [bus_pkg::SLAVE_COUNT-1:0] s_re_o,
	output bus_pkg::addr_t                  s_addr_o,
	output bus_pkg::data_t                  s_wdata_o,
	output bus_pkg::sel_t                   s_sel_o,
	input  wire bus_pkg::data_t             devtbl_rdata_i,
	input  wire bus_pkg::data_t             intctrl_rdata_i,
	input  wire bus_pkg::data_t             ram_rdata_i
);

	// Indexed by slave_e
	localparam bus_pkg::addr_t SLAVE_BASE [bus_pkg::SLAVE_COUNT] = '{
		soc_map_pkg::DEVTBL_BASE,
		soc_map_pkg::INTCTRL_BASE,
		soc_map_pkg::RAM_BASE,
		soc_map_pkg::INVALID_BASE
	};

	bus_pkg::slave_e sel;
	bus_pkg::slave_e rd_sel_q;

	always_comb begin
		if (bus_addr_i >= soc_map_pkg::INVALID_BASE)
			sel = bus_pkg::SLV_INVALID;
		else if (bus_addr_i >= soc_map_pkg::RAM_BASE)
			sel = bus_pkg::SLV_RAM;
		else if (bus_addr_i >= soc_map_pkg::INTCTRL_BASE)
			sel = bus_pkg::SLV_INTCTRL;
		else
			sel = bus_pkg::SLV_DEVTBL;
	end

	// Every slave is always ready
	assign bus_rdy_o = bus_op_i != bus_pkg::OP_IDLE;

	always_comb begin
		s_we_o = '0;
		s_re_o = '0;
		s_we_o[sel] = bus_op_i == bus_pkg::OP_WRITE;
		s_re_o[sel] = bus_op_i == bus_pkg::OP_READ;
	end

	assign s_addr_o  = bus_addr_i - SLAVE_BASE[sel];
	assign s_wdata_o = bus_wdata_i;
	assign s_sel_o   = bus_sel_i;

	// Remember which slave answers the read on the next cycle
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			rd_sel_q <= bus_pkg::SLV_INVALID;
		else if (bus_op_i == bus_pkg::OP_READ)
			rd_sel_q <= sel;
	end

	// Unmapped space drops writes and reads back zero
	always_comb begin
		case (rd_sel_q)
			bus_pkg::SLV_DEVTBL:  bus_rdata_o = devtbl_rdata_i;
			bus_pkg::SLV_INTCTRL: bus_rdata_o = intctrl_rdata_i;
			bus_pkg::SLV_RAM:     bus_rdata_o = ram_rdata_i;
			default:              bus_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
// Round-robin arbiter muxing two master ports onto the shared bus
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  wire                              clk24mhz,
	input  wire                              rst_p,
	input  wire bus_pkg::op_e                m_op_i    [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::addr_t              m_addr_i  [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::data_t              m_wdata_i [bus_pkg::MASTER_COUNT],
	input  wire bus_pkg::sel_t               m_sel_i   [bus_pkg::MASTER_COUNT],
	output logic [bus_pkg::MASTER_COUNT-1:0] m_rdy_o,
	output bus_pkg::op_e                     bus_op_o,
	output bus_pkg::addr_t                   bus_addr_o,
	output bus_pkg::data_t                   bus_wdata_o,
	output bus_pkg::sel_t                    bus_sel_o,
	input  wire                              bus_rdy_i
);

	localparam int IDX_W = $clog2(bus_pkg::MASTER_COUNT);
	typedef logic [IDX_W-1:0] midx_t;

	midx_t gnt_q;
	midx_t cur;
	midx_t nxt;
	logic  accept;

	// An idle owner hands the bus over in the same cycle
	always_comb begin
		cur = gnt_q;
		if (m_op_i[gnt_q] == bus_pkg::OP_IDLE &&
				m_op_i[midx_t'(gnt_q + 1'b1)] != bus_pkg::OP_IDLE) begin
			cur = midx_t'(gnt_q + 1'b1);
		end
		nxt = midx_t'(cur + 1'b1);
	end

	// No master is served while the system reset is active
	assign bus_op_o    = rst_p ? bus_pkg::OP_IDLE : m_op_i[cur];
	assign bus_addr_o  = m_addr_i[cur];
	assign bus_wdata_o = m_wdata_i[cur];
	assign bus_sel_o   = m_sel_i[cur];

	assign accept = bus_rdy_i && bus_op_o != bus_pkg::OP_IDLE;

	always_comb begin
		for (int m = 0; m < bus_pkg::MASTER_COUNT; m++) begin
			m_rdy_o[m] = accept && cur == midx_t'(m);
		end
	end

	// After an accepted transfer the other master gets its turn
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			gnt_q <= '0;
		end else begin
			if (accept && m_op_i[nxt] != bus_pkg::OP_IDLE)
				gnt_q <= nxt;
			else
				gnt_q <= cur;
		end
	end

endmodule

`default_nettype wire

/* hw/reset_seq.sv */
// Reset stretch counter and software power-off latch
`timescale 1ns/1ns
`default_nettype none

module reset_seq #(
	parameter int RST_CYCLES = 16
) (
	input  wire                        clk24mhz,
	input  wire                        rst_p,
	input  wire soc_map_pkg::rst_cmd_e rst_cmd_i,
	output logic                       sys_rst_o,
	output logic                       power_off_o
);

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             restart;

	// Cold restart behaves as warm, there is no global set/reset path
	assign restart = rst_cmd_i == soc_map_pkg::RST_WARM || rst_cmd_i == soc_map_pkg::RST_COLD;

	always_ff @(posedge clk24mhz) begin
		if (rst_p || restart)
			cnt_q <= CNT_W'(RST_CYCLES);
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	assign sys_rst_o = cnt_q != '0;

	// Only the external reset brings the system back from power-off
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			power_off_o <= 1'b0;
		else if (rst_cmd_i == soc_map_pkg::RST_POWEROFF)
			power_off_o <= 1'b1;
	end

endmodule

`default_nettype wire

/* hw/soc_map_pkg.sv */
// Memory map bases and size, device identifiers, SoC identifier, interrupt count, reset commands
`default_nettype none

package soc_map_pkg;

	// Word bases of the 4 KB windows
	localparam bus_pkg::addr_t DEVTBL_BASE  = 30'h000;
	localparam bus_pkg::addr_t INTCTRL_BASE = 30'h400;
	localparam bus_pkg::addr_t RAM_BASE     = 30'h800;

	// Everything from byte address 0x3000 upward is unmapped
	localparam bus_pkg::addr_t INVALID_BASE = 30'hC00;

	// Size in bytes, reported for every slave
	localparam bus_pkg::data_t MAP_SIZE = 32'h0000_1000;

	localparam bus_pkg::data_t DEV_ID_DEVTBL  = 32'd7;
	localparam bus_pkg::data_t DEV_ID_INTCTRL = 32'd3;
	localparam bus_pkg::data_t DEV_ID_RAM     = 32'd1;
	localparam bus_pkg::data_t DEV_ID_INVALID = 32'd0;

	localparam bus_pkg::data_t SOC_ID = 32'd6;

	// Destinations are one per master
	localparam int IRQ_SRC_COUNT = 2;

	// Bit 1 requests a restart, bit 0 alone requests power-off
	typedef enum logic [1:0] {
		RST_NONE     = 2'b00,
		RST_WARM     = 2'b10,
		RST_POWEROFF = 2'b01,
		RST_COLD     = 2'b11
	} rst_cmd_e;

endpackage

`default_nettype wire

/* hw/bus_pkg.sv */
// Bus operation encoding, word and mask types, master and slave counts and slave indices
`default_nettype none

package bus_pkg;

	// Level-held bus operation, same encoding as the processor port
	typedef enum logic [1:0] {
		OP_IDLE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} op_e;

	// Word address, the byte address without its two low bits
	typedef logic [29:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  sel_t;

	localparam int MASTER_COUNT = 2;

	// Slave order also fixes the device table layout
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_INTCTRL = 2'd1,
		SLV_RAM     = 2'd2,
		SLV_INVALID = 2'd3
	} slave_e;

	localparam int SLAVE_COUNT = 4;

endpackage

`default_nettype wire
